/* project.f */
source/erx_pkg.sv
source/erx_frame_align.sv
source/erx_protocol.sv
source/erx_dispatch.sv
source/erx_top.sv
verif/erx_clkgen.sv
verif/erx_tb.sv

/* Makefile */
# Verilator build and run for the rx link testbench

TOP = erx_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module $(TOP) \
		-o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Testbench failed" sim.log; then \
		echo "simulation reported a failure"; exit 1; \
	fi
	@grep -q "Testbench passed" sim.log

lint:
	verilator --lint-only --timing -Wall -f project.f --top-module $(TOP)
	verilator --lint-only -Wall -f project.f --top-module erx_top

clean:
	rm -rf obj_dir sim.log

/* verif/erx_tb.sv */
// testbench for the rx link protocol side
// serializer byte queue, reference decode, port compare tasks, timeout

`timescale 1ns/1ps
`default_nettype none

module erx_tb
   import erx_pkg::*;
();

   localparam logic [addr_w-1:0] win_base = 32'h8000_0000;
   localparam logic [addr_w-1:0] win_mask = 32'hF000_0000;
   localparam int n_txn = 48;

   typedef struct packed {
      logic [addr_w-1:0] addr;
      logic [data_w-1:0] data;
      logic [addr_w-1:0] src;
      datamode_e         dm;
      logic [ctrl_w-1:0] ctrl;
   } item_t;

   logic                    rx_lclk_div4;
   logic                    rst;
   logic [link_bytes-1:0]   rx_frame_par;
   logic [8*link_bytes-1:0] rx_data_par;
   logic                    wr_wait;
   logic                    rd_wait;
   logic                    wr_access, rd_access;
   logic [addr_w-1:0]       wr_dstaddr, rd_dstaddr, rd_srcaddr;
   logic [data_w-1:0]       wr_data;
   datamode_e               wr_datamode, rd_datamode;
   logic [ctrl_w-1:0]       wr_ctrlmode, rd_ctrlmode;
   logic [7:0]              drop_count;
   logic                    rx_wr_wait, rx_rd_wait;

   erx_clkgen #(.period_ns(4), .rst_cycles(2)) erx_clkgen_inst (
      .clk (rx_lclk_div4),
      .rst (rst)
   );

   erx_top #(.filter_base(win_base), .filter_mask(win_mask)) erx_top_inst (
      .rx_lclk_div4 (rx_lclk_div4), .rst (rst),
      .rx_frame_par (rx_frame_par), .rx_data_par (rx_data_par),
      .wr_wait (wr_wait), .rd_wait (rd_wait),
      .wr_access (wr_access), .wr_dstaddr (wr_dstaddr), .wr_data (wr_data),
      .wr_datamode (wr_datamode), .wr_ctrlmode (wr_ctrlmode),
      .rd_access (rd_access), .rd_dstaddr (rd_dstaddr), .rd_srcaddr (rd_srcaddr),
      .rd_datamode (rd_datamode), .rd_ctrlmode (rd_ctrlmode),
      .drop_count (drop_count), .rx_wr_wait (rx_wr_wait), .rx_rd_wait (rx_rd_wait)
   );

   integer            seed = 55366;
   logic [7:0]        byte_q[$];      // serializer model in wire order
   logic              frm_q[$];
   item_t             wr_q[$];        // expected write port items
   item_t             rd_q[$];
   int                exp_drops;
   int                pushed;         // bytes queued since reset
   int                frame_left;     // frame bytes not yet on the wire
   int                next_txn;
   int                cycles;
   int                cycle_limit;

   // transaction table
   logic              t_write[n_txn];
   datamode_e         t_dm[n_txn];
   logic [ctrl_w-1:0] t_ctrl[n_txn];
   logic [addr_w-1:0] t_dst[n_txn];
   int                t_nstr[n_txn];  // extra stream groups
   logic [data_w-1:0] t_data[n_txn][4];
   logic [addr_w-1:0] t_src[n_txn][4];

   // ####################################################################
   // reference model
   // ####################################################################
   function automatic void expect_txn(input int t);
      logic [addr_w-1:0] dst;
      item_t             it;
      for (int k = 0; k <= t_nstr[t]; k++) begin
         dst = t_dst[t] + addr_w'(stream_step * k);   // stream steps by a doubleword
         it  = '{dst, t_data[t][k], t_src[t][k], t_dm[t], t_ctrl[t]};
         if ((dst & win_mask) != win_base) begin
            if (exp_drops < 255) exp_drops++;          // counter saturates
         end else if (t_write[t]) begin
            wr_q.push_back(it);
         end else begin
            rd_q.push_back(it);
         end
      end
   endfunction

   task automatic stop_on_error();
      $display("Testbench failed");
      $fatal(1);
   endtask

   task automatic check_wr(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
                           input datamode_e dm, input logic [ctrl_w-1:0] ctrl);
      if (wr_dstaddr !== addr || wr_data !== data || wr_datamode !== dm
          || wr_ctrlmode !== ctrl) begin
         $display("error: %0t ns: write got %h %h %0d %h, expected %h %h %0d %h", $time,
                  wr_dstaddr, wr_data, wr_datamode, wr_ctrlmode, addr, data, dm, ctrl);
         stop_on_error();
      end
   endtask

   task automatic check_rd(input logic [addr_w-1:0] addr, input logic [addr_w-1:0] src,
                           input datamode_e dm, input logic [ctrl_w-1:0] ctrl);
      if (rd_dstaddr !== addr || rd_srcaddr !== src || rd_datamode !== dm
          || rd_ctrlmode !== ctrl) begin
         $display("error: %0t ns: read got %h %h %0d %h, expected %h %h %0d %h", $time,
                  rd_dstaddr, rd_srcaddr, rd_datamode, rd_ctrlmode, addr, src, dm, ctrl);
         stop_on_error();
      end
   endtask

   task automatic check_drops(input logic [7:0] expected);
      if (drop_count !== expected) begin
         $display("error: %0t ns: drop_count %0d, expected %0d", $time, drop_count, expected);
         stop_on_error();
      end
   endtask

   task automatic check_wait(input logic exp_wr, input logic exp_rd);
      if (rx_wr_wait !== exp_wr || rx_rd_wait !== exp_rd) begin
         $display("error: %0t ns: rx wait %b%b, expected %b%b", $time,
                  rx_wr_wait, rx_rd_wait, exp_wr, exp_rd);
         stop_on_error();
      end
   endtask

   // ####################################################################
   // serializer model
   // ####################################################################
   task automatic push_byte(input logic [7:0] b, input logic f);
      byte_q.push_back(b);
      frm_q.push_back(f);
      pushed++;
      if (f) frame_left++;
   endtask

   // gap chosen so that start positions cycle through 7..0
   task automatic push_frame(input int t);
      logic [103:0] pkt;
      logic [63:0]  strm;
      int           tgt;
      int           gap;
      tgt = 7 - (t % link_bytes);
      gap = ((7 - tgt) - (pushed % link_bytes) + link_bytes) % link_bytes;
      if (gap == 0) gap = link_bytes;                   // at least one idle byte
      gap = gap + link_bytes * ($random(seed) & 1);
      repeat (gap) push_byte(8'h00, 1'b0);
      push_byte(8'($random(seed)), 1'b1);              // tran byte where the frame rises
      pkt = {t_ctrl[t], t_dst[t], t_dm[t], t_write[t], 1'b1, t_data[t][0], t_src[t][0]};
      for (int i = 0; i < 13; i++) push_byte(pkt[103-8*i -: 8], 1'b1);
      for (int k = 1; k <= t_nstr[t]; k++) begin
         strm = {t_data[t][k], t_src[t][k]};
         for (int i = 0; i < 8; i++) push_byte(strm[63-8*i -: 8], 1'b1);
      end
      expect_txn(t);
   endtask

   initial begin
      int total;
      rx_frame_par = '0;
      rx_data_par  = '0;
      wr_wait      = 1'b0;
      rd_wait      = 1'b0;
      exp_drops    = 0;
      pushed       = 0;
      frame_left   = 0;
      next_txn     = 0;
      cycles       = 0;
      total        = 0;
      for (int t = 0; t < n_txn; t++) begin
         t_write[t] = 1'($random(seed) & 1);
         t_dm[t]    = datamode_e'($random(seed) & 3);
         t_ctrl[t]  = ctrl_w'($random(seed));
         t_dst[t]   = {(($random(seed) & 3) != 0) ? 4'h8 : 4'(($random(seed) % 8) & 7),
                       28'($random(seed))};       // mostly inside the window
         t_nstr[t]  = (t_write[t] && ($random(seed) & 3) == 0) ? 1 + ($random(seed) & 1) + 
                      ($random(seed) & 1) : 0;
         for (int k = 0; k < 4; k++) begin
            t_data[t][k] = $random(seed);
            t_src[t][k]  = $random(seed);
         end
         total = total + 14 + 8 * t_nstr[t] + 2 * link_bytes;   // worst case gap
      end
      cycle_limit = total / link_bytes + 200;
      @(negedge rst);
      wait (next_txn == n_txn && frame_left == 0);   // last frame byte is on the wire
      repeat (6) @(negedge rx_lclk_div4);          // access lands 5 edges after its group
      if (wr_q.size() != 0 || rd_q.size() != 0) begin
         $display("%0d writes and %0d reads never came out", wr_q.size(), rd_q.size());
         stop_on_error();
      end else begin
         check_drops(8'(exp_drops));
         $display("Testbench passed");
         $finish;
      end
   end

   // drive side sets the wait levels, refills and puts one group out per falling edge
   always @(negedge rx_lclk_div4) begin
      if (!rst) begin
         if (wr_wait) wr_wait = ($random(seed) & 3) != 0;   // short bursts
         else         wr_wait = ($random(seed) & 31) == 0;
         if (rd_wait) rd_wait = ($random(seed) & 3) != 0;
         else         rd_wait = ($random(seed) & 31) == 0;
         while (byte_q.size() < link_bytes) begin
            if (next_txn < n_txn && !(t_write[next_txn] ? wr_wait : rd_wait)) begin
               push_frame(next_txn);
               next_txn++;
            end else begin
               push_byte(8'h00, 1'b0);                  // idle or held off by wait
            end
         end
         for (int i = 0; i < link_bytes; i++) begin
            rx_data_par[8*(link_bytes-1-i) +: 8] = byte_q.pop_front();   // byte 7 first
            rx_frame_par[link_bytes-1-i]         = frm_q.pop_front();
            if (rx_frame_par[link_bytes-1-i]) frame_left--;
         end
      end
   end

   // ####################################################################
   // compare side
   // ####################################################################
   always @(negedge rx_lclk_div4) begin : compare
      item_t e;
      if (!rst) begin
         if (wr_access) begin
            if (wr_q.size() == 0) begin
               $display("write access at %0t ns with nothing expected", $time);
               stop_on_error();
            end else begin
               e = wr_q.pop_front();
               check_wr(e.addr, e.data, e.dm, e.ctrl);
            end
         end
         if (rd_access) begin
            if (rd_q.size() == 0) begin
               $display("read access at %0t ns with nothing expected", $time);
               stop_on_error();
            end else begin
               e = rd_q.pop_front();
               check_rd(e.addr, e.src, e.dm, e.ctrl);
            end
         end
      end
   end

   // wait levels pass straight through with inputs settled since the falling edge
   always @(posedge rx_lclk_div4) begin
      check_wait(wr_wait, rd_wait);
   end

   always @(posedge rx_lclk_div4) begin
      cycles++;
      if (cycles > cycle_limit) begin
         $display("timeout: run did not finish within %0d cycles", cycle_limit);
         stop_on_error();
      end
   end

endmodule

`default_nettype wire

/* verif/erx_clkgen.sv */
// testbench clock and reset source
// free running clock, synchronous reset held for a few cycles

`timescale 1ns/1ps
`default_nettype none

module erx_clkgen #(
   parameter int period_ns  = 4,
   parameter int rst_cycles = 2
) (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #(period_ns / 2.0) clk = ~clk;
   end

   // release away from the sampling edge
   initial begin
      rst = 1'b1;
      repeat (rst_cycles) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
   end

endmodule

`default_nettype wire

/* source/erx_top.sv */
// rx protocol side of the parallel link
// frame align -> 3 stage decode -> window filter and port dispatch

`timescale 1ns/1ps
`default_nettype none

module erx_top
   import erx_pkg::*;
#(
   parameter logic [addr_w-1:0] filter_base = 32'h0800_0000,
   parameter logic [addr_w-1:0] filter_mask = 32'hFFF0_0000
) (
   input  wire                      rx_lclk_div4,
   input  wire                      rst,
   input  wire  [link_bytes-1:0]    rx_frame_par,
   input  wire  [8*link_bytes-1:0]  rx_data_par,
   input  wire                      wr_wait,
   input  wire                      rd_wait,
   output logic                     wr_access,
   output logic [addr_w-1:0]        wr_dstaddr,
   output logic [data_w-1:0]        wr_data,
   output datamode_e                wr_datamode,
   output logic [ctrl_w-1:0]        wr_ctrlmode,
   output logic                     rd_access,
   output logic [addr_w-1:0]        rd_dstaddr,
   output logic [addr_w-1:0]        rd_srcaddr,
   output datamode_e                rd_datamode,
   output logic [ctrl_w-1:0]        rd_ctrlmode,
   output logic [7:0]               drop_count,
   output logic                     rx_wr_wait,
   output logic                     rx_rd_wait
);

   // align -> protocol
   logic [align_w-1:0]       align_pos;
   logic                     align_active;
   logic [8*link_bytes-1:0]  data_grp;
   logic [link_bytes-1:0]    frame_grp;

   // protocol -> dispatch
   logic                     dec_access;
   logic                     dec_write;
   datamode_e                dec_datamode;
   logic [ctrl_w-1:0]        dec_ctrlmode;
   logic [addr_w-1:0]        dec_dstaddr;
   logic [addr_w-1:0]        dec_srcaddr;
   logic [data_w-1:0]        dec_data;

   erx_frame_align erx_frame_align_inst (
      .rx_lclk_div4 (rx_lclk_div4),
      .rst          (rst),
      .rx_frame_par (rx_frame_par),
      .rx_data_par  (rx_data_par),
      .align_pos    (align_pos),
      .align_active (align_active),
      .data_grp     (data_grp),
      .frame_grp    (frame_grp)
   );

   erx_protocol erx_protocol_inst (
      .rx_lclk_div4 (rx_lclk_div4),
      .rst          (rst),
      .align_pos    (align_pos),
      .align_active (align_active),
      .data_grp     (data_grp),
      .frame_grp    (frame_grp),
      .dec_access   (dec_access),
      .dec_write    (dec_write),
      .dec_datamode (dec_datamode),
      .dec_ctrlmode (dec_ctrlmode),
      .dec_dstaddr  (dec_dstaddr),
      .dec_srcaddr  (dec_srcaddr),
      .dec_data     (dec_data)
   );

   erx_dispatch #(
      .filter_base (filter_base),
      .filter_mask (filter_mask)
   ) erx_dispatch_inst (
      .rx_lclk_div4 (rx_lclk_div4),
      .rst          (rst),
      .dec_access   (dec_access),
      .dec_write    (dec_write),
      .dec_datamode (dec_datamode),
      .dec_ctrlmode (dec_ctrlmode),
      .dec_dstaddr  (dec_dstaddr),
      .dec_srcaddr  (dec_srcaddr),
      .dec_data     (dec_data),
      .wr_wait      (wr_wait),
      .rd_wait      (rd_wait),
      .wr_access    (wr_access),
      .wr_dstaddr   (wr_dstaddr),
      .wr_data      (wr_data),
      .wr_datamode  (wr_datamode),
      .wr_ctrlmode  (wr_ctrlmode),
      .rd_access    (rd_access),
      .rd_dstaddr   (rd_dstaddr),
      .rd_srcaddr   (rd_srcaddr),
      .rd_datamode  (rd_datamode),
      .rd_ctrlmode  (rd_ctrlmode),
      .drop_count   (drop_count),
      .rx_wr_wait   (rx_wr_wait),
      .rx_rd_wait   (rx_rd_wait)
   );

endmodule

`default_nettype wire

/* source/erx_dispatch.sv */
// address window filter for decoded rx transactions
// write / read port routing, saturating count of dropped accesses

`timescale 1ns/1ps
`default_nettype none

module erx_dispatch
   import erx_pkg::*;
#(
   parameter logic [addr_w-1:0] filter_base = 32'h0800_0000,
   parameter logic [addr_w-1:0] filter_mask = 32'hFFF0_0000
) (
   input  wire                 rx_lclk_div4,
   input  wire                 rst,
   // decoded transaction
   input  wire                 dec_access,
   input  wire                 dec_write,
   input  wire datamode_e      dec_datamode,
   input  wire  [ctrl_w-1:0]   dec_ctrlmode,
   input  wire  [addr_w-1:0]   dec_dstaddr,
   input  wire  [addr_w-1:0]   dec_srcaddr,
   input  wire  [data_w-1:0]   dec_data,
   // consumer wait levels
   input  wire                 wr_wait,
   input  wire                 rd_wait,
   // write port
   output logic                wr_access,
   output logic [addr_w-1:0]   wr_dstaddr,
   output logic [data_w-1:0]   wr_data,
   output datamode_e           wr_datamode,
   output logic [ctrl_w-1:0]   wr_ctrlmode,
   // read port
   output logic                rd_access,
   output logic [addr_w-1:0]   rd_dstaddr,
   output logic [addr_w-1:0]   rd_srcaddr,
   output datamode_e           rd_datamode,
   output logic [ctrl_w-1:0]   rd_ctrlmode,
   // status and wait back to the link
   output logic [7:0]          drop_count,
   output logic                rx_wr_wait,
   output logic                rx_rd_wait
);

   logic hit;      // dstaddr falls inside the window
   logic wr_hit;
   logic rd_hit;
   logic miss;

   // ####################################################################
   // window compare
   // ####################################################################
   assign hit    = (dec_dstaddr & filter_mask) == filter_base;
   assign wr_hit = dec_access & hit & dec_write;
   assign rd_hit = dec_access & hit & ~dec_write;
   assign miss   = dec_access & ~hit;

   always_ff @(posedge rx_lclk_div4) begin
      if (rst) begin
         wr_access  <= 1'b0;
         rd_access  <= 1'b0;
         drop_count <= '0;
      end else begin
         wr_access <= wr_hit;
         rd_access <= rd_hit;
         if (miss && drop_count != 8'hFF) begin
            drop_count <= drop_count + 8'd1;   // sticks at 255
         end
      end
   end

   // payloads only load on a hit for their own port
   always_ff @(posedge rx_lclk_div4) begin
      if (wr_hit) begin
         wr_dstaddr  <= dec_dstaddr;
         wr_data     <= dec_data;
         wr_datamode <= dec_datamode;
         wr_ctrlmode <= dec_ctrlmode;
      end
      if (rd_hit) begin
         rd_dstaddr  <= dec_dstaddr;
         rd_srcaddr  <= dec_srcaddr;   // return address for the response
         rd_datamode <= dec_datamode;
         rd_ctrlmode <= dec_ctrlmode;
      end
   end

   // ####################################################################
   // wait levels go straight back to the remote transmitter
   // ####################################################################
   assign rx_wr_wait = wr_wait;
   assign rx_rd_wait = rd_wait;

   // one transaction feeds exactly one port
   a_one_port : assert property (
      @(posedge rx_lclk_div4) disable iff (rst)
      !(wr_access && rd_access)
   );

endmodule

`default_nettype wire

/* source/erx_protocol.sv */
// three stage transaction decoder for the rx link
// gathers the 14 packet bytes over up to three groups, handles streamed writes

`timescale 1ns/1ps
`default_nettype none

module erx_protocol
   import erx_pkg::*;
(
   input  wire                      rx_lclk_div4,
   input  wire                      rst,
   input  wire  [align_w-1:0]       align_pos,
   input  wire                      align_active,
   input  wire  [8*link_bytes-1:0]  data_grp,
   input  wire  [link_bytes-1:0]    frame_grp,
   output logic                     dec_access,
   output logic                     dec_write,
   output datamode_e                dec_datamode,
   output logic [ctrl_w-1:0]        dec_ctrlmode,
   output logic [addr_w-1:0]        dec_dstaddr,
   output logic [addr_w-1:0]        dec_srcaddr,
   output logic [data_w-1:0]        dec_data
);

   localparam int pkt_bytes = 14;            // tran byte + 104 bit transaction
   localparam int pkt_w     = 8*pkt_bytes;
   localparam int grp_w     = 8*link_bytes;

   // ####################################################################
   // byte picker
   // packet byte i sits at wire offset (first byte of frame) + i,
   // counted from the start of the group that holds the rising edge
   // ####################################################################
   function automatic logic [pkt_w-1:0] fill_pkt(
      input logic [pkt_w-1:0]   pkt_in,
      input logic [align_w-1:0] pos,
      input logic [grp_w-1:0]   grp,
      input int                 grp_idx,    // which group of the frame this is
      input int                 lo_byte     // first packet byte to touch
   );
      logic [pkt_w-1:0] pkt_out;
      int               off;
      int               abs_idx;
      pkt_out = pkt_in;
      off     = (link_bytes - 1) - int'(pos);   // pos 7 -> offset 0
      for (int i = 0; i < pkt_bytes; i++) begin
         abs_idx = off + i;
         if (i >= lo_byte && abs_idx / link_bytes == grp_idx) begin
            pkt_out[pkt_w-1-8*i -: 8] = grp[grp_w-1-8*(abs_idx % link_bytes) -: 8];
         end
      end
      return pkt_out;
   endfunction

   // stage 0 / 1 state
   logic                 active_0, active_1;
   logic [align_w-1:0]   pos_0, pos_1;
   logic [pkt_w-1:0]     pkt_0, pkt_1;

   // stage 2 state
   logic                 stream_2;          // next group is another write
   logic [align_w-1:0]   pos_2;             // held while streaming
   logic [grp_w-1:0]     grp_d1, grp_d2;    // two previous groups
   logic [link_bytes-1:0] frm_d1;
   logic [pkt_w-1:0]     pkt_norm;          // completed first packet
   logic [pkt_w-1:0]     pkt_strm;          // data/srcaddr of a stream group
   logic [align_w-1:0]   nx_pos;
   logic                 nx_active;
   logic [2*link_bytes-1:0] frm_win;

   // ####################################################################
   // stages 0 and 1: current and next group
   // ####################################################################
   always_ff @(posedge rx_lclk_div4) begin
      if (rst) begin
         active_0 <= 1'b0;
         active_1 <= 1'b0;
      end else begin
         active_0 <= align_active;
         active_1 <= active_0;
      end
   end

   always_ff @(posedge rx_lclk_div4) begin
      pos_0 <= align_pos;
      pkt_0 <= fill_pkt('0, align_pos, data_grp, 0, 0);   // first group only
      pos_1 <= pos_0;
      pkt_1 <= fill_pkt(pkt_0, pos_0, data_grp, 1, 0);
      grp_d1 <= data_grp;   // history for stream groups
      grp_d2 <= grp_d1;
      frm_d1 <= frame_grp;
   end

   // ####################################################################
   // stage 2: late starts finish here, stream groups are cut from a
   // three group window with the held start position
   // ####################################################################
   always_comb begin
      pkt_norm = fill_pkt(pkt_1, pos_1, data_grp, 2, 0);
      pkt_strm = fill_pkt('0, pos_2, grp_d2, 0, 6);   // bytes 6..13 = data, srcaddr
      pkt_strm = fill_pkt(pkt_strm, pos_2, grp_d1, 1, 6);
      pkt_strm = fill_pkt(pkt_strm, pos_2, data_grp, 2, 6);
   end

   // item issued this edge, and where its frame bit after the end sits
   assign nx_pos    = stream_2 ? pos_2 : pos_1;
   assign nx_active = stream_2 | active_1;
   assign frm_win   = {frm_d1, frame_grp};   // byte after the end lands at pos + 2

   always_ff @(posedge rx_lclk_div4) begin
      if (rst) begin
         dec_access <= 1'b0;
         stream_2   <= 1'b0;
      end else begin
         if (!stream_2) begin
            dec_access <= active_1 & pkt_norm[64];   // access bit, gated
         end
         stream_2 <= nx_active & frm_win[int'(nx_pos) + 2];
      end
   end

   always_ff @(posedge rx_lclk_div4) begin
      if (stream_2) begin
         dec_dstaddr <= dec_dstaddr + addr_w'(stream_step);   // command held
         dec_data    <= pkt_strm[63:32];
         dec_srcaddr <= pkt_strm[31:0];
      end else begin
         pos_2        <= pos_1;
         dec_ctrlmode <= pkt_norm[103:100];
         dec_dstaddr  <= pkt_norm[99:68];
         dec_datamode <= datamode_e'(pkt_norm[67:66]);
         dec_write    <= pkt_norm[65];
         dec_data     <= pkt_norm[63:32];
         dec_srcaddr  <= pkt_norm[31:0];
      end
   end

   // a fresh access always traces back to a frame edge three groups ago
   a_access_origin : assert property (
      @(posedge rx_lclk_div4) disable iff (rst)
      $rose(dec_access) |-> $past(align_active, 3)
   );

endmodule

`default_nettype wire

/* source/erx_frame_align.sv */
// frame edge finder for the parallel rx link
// registers start position and active flag with the byte group

`timescale 1ns/1ps
`default_nettype none

module erx_frame_align
   import erx_pkg::*;
(
   input  wire                      rx_lclk_div4,
   input  wire                      rst,
   input  wire  [link_bytes-1:0]    rx_frame_par,   // bit 7 first on the wire
   input  wire  [8*link_bytes-1:0]  rx_data_par,    // byte 7 first on the wire
   output logic [align_w-1:0]       align_pos,      // byte where the frame rose
   output logic                     align_active,   // a frame starts in this group
   output logic [8*link_bytes-1:0]  data_grp,
   output logic [link_bytes-1:0]    frame_grp
);

   logic                  frame_prev;   // last frame bit of the previous group
   logic [link_bytes-1:0] rise;         // 0->1 transitions, one per byte
   logic [align_w-1:0]    rise_pos;
   logic                  rise_any;

   // previous bit for byte 7 comes from the group before
   assign rise = rx_frame_par & ~{frame_prev, rx_frame_par[link_bytes-1:1]};

   // first edge on the wire wins, so highest index has priority
   always_comb begin
      rise_pos = '0;
      rise_any = 1'b0;
      for (int i = 0; i < link_bytes; i++) begin
         if (rise[i]) begin
            rise_pos = align_w'(i);
            rise_any = 1'b1;
         end
      end
   end

   // control flags
   always_ff @(posedge rx_lclk_div4) begin
      if (rst) begin
         frame_prev   <= 1'b0;
         align_active <= 1'b0;
      end else begin
         frame_prev   <= rx_frame_par[0];
         align_active <= rise_any;
      end
   end

   // position and groups move together with the flag
   always_ff @(posedge rx_lclk_div4) begin
      align_pos <= rise_pos;
      data_grp  <= rx_data_par;
      frame_grp <= rx_frame_par;   // needed later for the stream check
   end

   // nothing may look like a frame start straight out of reset
   a_idle_after_rst : assert property (
      @(posedge rx_lclk_div4) rst |=> !align_active
   );

endmodule

`default_nettype wire

/* source/erx_pkg.sv */
// shared types and widths for the link receive path
// datamode enum, link geometry, transaction field widths

`default_nettype none

package erx_pkg;

   // ####################################################################
   // access size encoding, as carried in the transaction
   // ####################################################################
   typedef enum logic [1:0] {
      dm_byte   = 2'b00,   // 8 bit
      dm_half   = 2'b01,   // 16 bit
      dm_word   = 2'b10,   // 32 bit
      dm_double = 2'b11    // 64 bit, two halves
   } datamode_e;

   // ####################################################################
   // link and field geometry
   // ####################################################################
   localparam int link_bytes = 8;    // bytes per rx_lclk_div4 cycle
   localparam int align_w    = 3;    // frame start position in a group

   localparam int addr_w     = 32;   // dstaddr and srcaddr
   localparam int data_w     = 32;   // data payload
   localparam int ctrl_w     = 4;    // ctrlmode

   // each streamed write lands on the next doubleword
   localparam int stream_step = 8;

endpackage

`default_nettype wire
